//--- dcache.f
dcache_pkg.sv
dcache_tags.sv
dcache_data.sv
dcache_ctrl.sv
dcache.sv
dcache_tb_clk.sv
dcache_tb_mem.sv
dcache_tb.sv

//--- dcache.sv
module dcache
        import dcache_pkg::*;
(
        input  logic     CLK,
        input  logic     nRST,
        input  cpu_req_t cpu_req,
        input  logic     halt,
        output logic     dhit,
        output word_t    rdata,
        output logic     flushed,
        output mem_req_t mem_req,
        input  logic     dwait,
        input  word_t    dload
);

        logic [IDX_W-1:0]       idx;
        logic [TAG_W-1:0]       tag;
        logic                   fill;
        logic                   mark_dirty;
        logic                   clear;
        logic                   touch;
        logic                   tag_way;
        tag_entry_t [WAYS-1:0]  entries;
        logic                   hit;
        logic                   hit_way;
        logic                   victim_way;
        logic                   data_way;
        logic                   word_sel;
        logic                   wr_en;
        word_t                  wr_data;
        word_t                  rd_word;

        dcache_tags u_tags (
                .CLK        (CLK),
                .nRST       (nRST),
                .idx        (idx),
                .tag        (tag),
                .fill       (fill),
                .mark_dirty (mark_dirty),
                .clear      (clear),
                .touch      (touch),
                .way        (tag_way),
                .entries    (entries),
                .hit        (hit),
                .hit_way    (hit_way),
                .victim_way (victim_way)
        );

        dcache_data u_data (
                .CLK      (CLK),
                .nRST     (nRST),
                .idx      (idx),
                .way      (data_way),
                .word_sel (word_sel),
                .wr_en    (wr_en),
                .wr_data  (wr_data),
                .rd_word  (rd_word)
        );

        dcache_ctrl u_ctrl (
                .CLK        (CLK),
                .nRST       (nRST),
                .cpu_req    (cpu_req),
                .halt       (halt),
                .dhit       (dhit),
                .rdata      (rdata),
                .flushed    (flushed),
                .mem_req    (mem_req),
                .dwait      (dwait),
                .dload      (dload),
                .fill       (fill),
                .mark_dirty (mark_dirty),
                .clear      (clear),
                .touch      (touch),
                .tag_way    (tag_way),
                .idx        (idx),
                .tag        (tag),
                .entries    (entries),
                .hit        (hit),
                .hit_way    (hit_way),
                .victim_way (victim_way),
                .data_way   (data_way),
                .word_sel   (word_sel),
                .wr_en      (wr_en),
                .wr_data    (wr_data),
                .rd_word    (rd_word)
        );

endmodule

//--- dcache_ctrl.sv
module dcache_ctrl
        import dcache_pkg::*;
(
        input  logic                  CLK,
        input  logic                  nRST,
        input  cpu_req_t              cpu_req,
        input  logic                  halt,
        output logic                  dhit,
        output word_t                 rdata,
        output logic                  flushed,
        output mem_req_t              mem_req,
        input  logic                  dwait,
        input  word_t                 dload,
        output logic                  fill,
        output logic                  mark_dirty,
        output logic                  clear,
        output logic                  touch,
        output logic                  tag_way,
        output logic [IDX_W-1:0]      idx,
        output logic [TAG_W-1:0]      tag,
        input  tag_entry_t [WAYS-1:0] entries,
        input  logic                  hit,
        input  logic                  hit_way,
        input  logic                  victim_way,
        output logic                  data_way,
        output logic                  word_sel,
        output logic                  wr_en,
        output word_t                 wr_data,
        input  word_t                 rd_word
);

        typedef enum logic [2:0] {
                LOOKUP,
                WB0,
                WB1,
                FILL0,
                FILL1,
                FLUSH,
                FLUSHED
        } state_t;

        state_t state, next_state;

        // way being written back or filled
        logic cur_way, cur_way_n;

        // set counter for the halt walk, one past the last set ends it
        logic [3:0] fcnt, fcnt_n;
        logic       flushing, flushing_n;

        logic         flush_way;
        dcache_addr_t req_addr;
        dcache_addr_t wb_addr;
        dcache_addr_t fill_addr;

        assign req_addr = cpu_req.addr;
        assign idx      = flushing ? fcnt[IDX_W-1:0] : req_addr.idx;
        assign tag      = req_addr.tag;
        assign rdata    = rd_word;
        assign flushed  = (state == FLUSHED);

        // first valid way of the set under the flush counter
        assign flush_way = entries[0].valid ? 1'b0 : 1'b1;

        always_comb begin
                wb_addr        = '0;
                wb_addr.tag    = entries[cur_way].tag;
                wb_addr.idx    = idx;
                wb_addr.blkoff = word_sel;
                fill_addr        = req_addr;
                fill_addr.blkoff = word_sel;
                fill_addr.bytoff = '0;
        end

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        state    <= LOOKUP;
                        cur_way  <= 1'b0;
                        fcnt     <= '0;
                        flushing <= 1'b0;
                end else begin
                        state    <= next_state;
                        cur_way  <= cur_way_n;
                        fcnt     <= fcnt_n;
                        flushing <= flushing_n;
                end
        end

        always_comb begin
                next_state = state;
                cur_way_n  = cur_way;
                fcnt_n     = fcnt;
                flushing_n = flushing;
                dhit       = 1'b0;
                fill       = 1'b0;
                mark_dirty = 1'b0;
                clear      = 1'b0;
                touch      = 1'b0;
                tag_way    = cur_way;
                data_way   = cur_way;
                word_sel   = 1'b0;
                wr_en      = 1'b0;
                wr_data    = dload;
                mem_req    = '0;

                case (state)
                LOOKUP: begin
                        tag_way  = hit_way;
                        data_way = hit_way;
                        word_sel = req_addr.blkoff;
                        wr_data  = cpu_req.wdata;
                        if (halt) begin
                                next_state = FLUSH;
                                flushing_n = 1'b1;
                                fcnt_n     = '0;
                        end else if (cpu_req.ren || cpu_req.wen) begin
                                if (hit) begin
                                        dhit  = 1'b1;
                                        touch = 1'b1;
                                        if (cpu_req.wen) begin
                                                wr_en      = 1'b1;
                                                mark_dirty = 1'b1;
                                        end
                                end else begin
                                        // miss, evict the LRU way
                                        cur_way_n = victim_way;
                                        if (entries[victim_way].dirty) begin
                                                next_state = WB0;
                                        end else begin
                                                next_state = FILL0;
                                        end
                                end
                        end
                end
                WB0: begin
                        mem_req.wen   = 1'b1;
                        mem_req.addr  = wb_addr;
                        mem_req.wdata = rd_word;
                        if (!dwait) begin
                                next_state = WB1;
                        end
                end
                WB1: begin
                        word_sel      = 1'b1;
                        mem_req.wen   = 1'b1;
                        mem_req.addr  = wb_addr;
                        mem_req.wdata = rd_word;
                        if (!dwait) begin
                                if (flushing) begin
                                        clear      = 1'b1;
                                        next_state = FLUSH;
                                end else begin
                                        next_state = FILL0;
                                end
                        end
                end
                FILL0: begin
                        mem_req.ren  = 1'b1;
                        mem_req.addr = fill_addr;
                        if (!dwait) begin
                                wr_en      = 1'b1;
                                next_state = FILL1;
                        end
                end
                FILL1: begin
                        word_sel     = 1'b1;
                        mem_req.ren  = 1'b1;
                        mem_req.addr = fill_addr;
                        if (!dwait) begin
                                // second word in, block becomes valid
                                wr_en      = 1'b1;
                                fill       = 1'b1;
                                next_state = LOOKUP;
                        end
                end
                FLUSH: begin
                        if (fcnt == 4'(SETS)) begin
                                next_state = FLUSHED;
                        end else if (entries[0].valid || entries[1].valid) begin
                                tag_way = flush_way;
                                if (entries[flush_way].dirty) begin
                                        cur_way_n  = flush_way;
                                        next_state = WB0;
                                end else begin
                                        clear = 1'b1;
                                end
                        end else begin
                                fcnt_n = fcnt + 4'd1;
                        end
                end
                FLUSHED: begin
                        next_state = FLUSHED;
                end
                default: begin
                        next_state = LOOKUP;
                end
                endcase
        end

endmodule

//--- dcache_data.sv
module dcache_data
        import dcache_pkg::*;
(
        input  logic             CLK,
        input  logic             nRST,
        input  logic [IDX_W-1:0] idx,
        input  logic             way,
        input  logic             word_sel,
        input  logic             wr_en,
        input  word_t            wr_data,
        output word_t            rd_word
);

        // set, way, then word within the block
        word_t [BLK_WORDS-1:0] mem [SETS][WAYS];

        assign rd_word = mem[idx][way][word_sel];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int s = 0; s < SETS; s++) begin
                                for (int w = 0; w < WAYS; w++) begin
                                        mem[s][w] <= '0;
                                end
                        end
                end else if (wr_en) begin
                        mem[idx][way][word_sel] <= wr_data;
                end
        end

endmodule

//--- dcache_pkg.sv
package dcache_pkg;

        // cache geometry
        localparam int WORD_W    = 32;
        localparam int SETS      = 8;
        localparam int IDX_W     = 3;
        localparam int TAG_W     = 26;
        localparam int WAYS      = 2;
        localparam int BLK_WORDS = 2;

        typedef logic [WORD_W-1:0] word_t;

        // byte address as the cache sees it
        typedef struct packed {
                logic [TAG_W-1:0] tag;
                logic [IDX_W-1:0] idx;
                logic             blkoff;
                logic [1:0]       bytoff;
        } dcache_addr_t;

        // one way of one set
        typedef struct packed {
                logic             valid;
                logic             dirty;
                logic [TAG_W-1:0] tag;
        } tag_entry_t;

        // load or store from the CPU
        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t wdata;
        } cpu_req_t;

        // word transfer to memory, held while dwait is high
        typedef struct packed {
                logic  ren;
                logic  wen;
                word_t addr;
                word_t wdata;
        } mem_req_t;

endpackage

//--- dcache_tags.sv
module dcache_tags
        import dcache_pkg::*;
(
        input  logic                  CLK,
        input  logic                  nRST,
        input  logic [IDX_W-1:0]      idx,
        input  logic [TAG_W-1:0]      tag,
        input  logic                  fill,
        input  logic                  mark_dirty,
        input  logic                  clear,
        input  logic                  touch,
        input  logic                  way,
        output tag_entry_t [WAYS-1:0] entries,
        output logic                  hit,
        output logic                  hit_way,
        output logic                  victim_way
);

        tag_entry_t [WAYS-1:0] tbl [SETS];

        // one bit per set, holds the most recently used way
        logic [SETS-1:0] lru;

        logic [WAYS-1:0] match;

        assign entries = tbl[idx];

        always_comb begin
                match = '0;
                for (int w = 0; w < WAYS; w++) begin
                        match[w] = tbl[idx][w].valid && (tbl[idx][w].tag == tag);
                end
        end

        assign hit        = |match;
        assign hit_way    = match[1];
        assign victim_way = ~lru[idx];

        always_ff @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        for (int s = 0; s < SETS; s++) begin
                                tbl[s] <= '0;
                        end
                        lru <= '0;
                end else begin
                        // new block comes in clean
                        if (fill) begin
                                tbl[idx][way].valid <= 1'b1;
                                tbl[idx][way].dirty <= 1'b0;
                                tbl[idx][way].tag   <= tag;
                        end
                        if (mark_dirty) begin
                                tbl[idx][way].dirty <= 1'b1;
                        end
                        if (clear) begin
                                tbl[idx][way].valid <= 1'b0;
                                tbl[idx][way].dirty <= 1'b0;
                        end
                        if (touch) begin
                                lru[idx] <= way;
                        end
                end
        end

endmodule

//--- dcache_tb.sv
module dcache_tb
        import dcache_pkg::*;
();

        localparam int          N_OPS      = 300;
        localparam int          TIMEOUT    = 200;
        localparam int          SAMPLE_DLY = 2;
        localparam logic [31:0] SEED       = 32'h70c1_4393;

        logic       CLK;
        logic       nRST;
        cpu_req_t   cpu_req;
        logic       halt;
        logic       dhit;
        word_t      rdata;
        logic       flushed;
        mem_req_t   mem_req;
        logic       dwait;
        word_t      dload;
        logic [1:0] next_wait;

        // expected memory image and tag state
        word_t            ref_img [word_t];
        logic [TAG_W-1:0] m_tag   [SETS][WAYS];
        bit               m_valid [SETS][WAYS];
        bit               m_dirty [SETS][WAYS];
        bit               m_mru   [SETS];

        logic [TAG_W-1:0] pool_tag [4] = '{26'h0000010, 26'h0123456, 26'h2a5a5a0, 26'h3ffffff};
        logic [IDX_W-1:0] pool_idx [3] = '{3'd1, 3'd4, 3'd6};

        int               errors;
        int               checks;
        int               wb_words;
        bit               aborted;
        bit               halting;
        logic [IDX_W-1:0] evict_idx;
        logic             evict_way;
        mem_req_t         prev_req;
        logic             prev_wait;

        dcache_tb_clk u_clk (.CLK(CLK), .nRST(nRST));

        dcache u_dut (
                .CLK     (CLK),
                .nRST    (nRST),
                .cpu_req (cpu_req),
                .halt    (halt),
                .dhit    (dhit),
                .rdata   (rdata),
                .flushed (flushed),
                .mem_req (mem_req),
                .dwait   (dwait),
                .dload   (dload)
        );

        dcache_tb_mem u_mem (
                .CLK       (CLK),
                .nRST      (nRST),
                .mem_req   (mem_req),
                .next_wait (next_wait),
                .dwait     (dwait),
                .dload     (dload)
        );

        function automatic word_t expected_word(input word_t a);
                if (ref_img.exists(a)) begin
                        return ref_img[a];
                end
                return a ^ 32'h5a5a_0000;
        endfunction

        function automatic bit dirty_at(input logic [IDX_W-1:0] i, input logic [TAG_W-1:0] t,
                                        input logic w);
                return m_valid[i][w] && m_dirty[i][w] && (m_tag[i][w] == t);
        endfunction

        task automatic check_word(input string name, input word_t exp, input word_t got);
                checks++;
                if (got !== exp) begin
                        errors++;
                        $display("Error at %0t: %s expected %h got %h", $time, name, exp, got);
                end
        endtask

        task automatic next_cycle();
                @(negedge CLK);
                next_wait = 2'($urandom_range(0, 3));
        endtask

        // memory bus watch just before each rising edge
        always begin
                dcache_addr_t a;
                @(negedge CLK);
                #SAMPLE_DLY;
                if (nRST) begin
                        checks++;
                        if ((prev_req.ren || prev_req.wen) && prev_wait &&
                            (mem_req !== prev_req)) begin
                                errors++;
                                $display("Error at %0t: mem_req expected %h got %h",
                                         $time, prev_req, mem_req);
                        end
                        if (mem_req.wen && !dwait) begin
                                a = mem_req.addr;
                                wb_words++;
                                checks++;
                                if (halting ? !(dirty_at(a.idx, a.tag, 1'b0) ||
                                                dirty_at(a.idx, a.tag, 1'b1))
                                            : !(a.idx == evict_idx &&
                                                dirty_at(a.idx, a.tag, evict_way))) begin
                                        errors++;
                                        $display("Write to %h is not to a dirty victim block",
                                                 mem_req.addr);
                                end
                                check_word("mem_req.wdata", expected_word(mem_req.addr),
                                           mem_req.wdata);
                        end
                end
                prev_req  = mem_req;
                prev_wait = dwait;
        end

        task automatic do_request(input word_t addr, input bit store, input word_t wdata);
                dcache_addr_t a;
                bit           hit;
                logic         way;
                int           exp_wb;
                int           cycles;
                a   = addr;
                hit = 1'b0;
                way = ~m_mru[a.idx];
                for (int w = 0; w < WAYS; w++) begin
                        if (m_valid[a.idx][w] && m_tag[a.idx][w] == a.tag) begin
                                hit = 1'b1;
                                way = w[0];
                        end
                end
                // victim goes back to memory only when dirty
                exp_wb        = (!hit && m_valid[a.idx][way] && m_dirty[a.idx][way]) ? 2 : 0;
                evict_idx     = a.idx;
                evict_way     = way;
                wb_words      = 0;
                cpu_req.ren   = !store;
                cpu_req.wen   = store;
                cpu_req.addr  = addr;
                cpu_req.wdata = wdata;
                #SAMPLE_DLY;
                check_word("dhit", 32'(hit), 32'(dhit));
                cycles = 0;
                while (dhit !== 1'b1) begin
                        if (cycles == TIMEOUT) begin
                                errors++;
                                aborted = 1'b1;
                                $display("Timeout: no dhit for request to address %h", addr);
                                return;
                        end
                        next_cycle();
                        #SAMPLE_DLY;
                        cycles++;
                end
                if (!store) begin
                        check_word("rdata", expected_word(addr), rdata);
                end
                check_word("write-back word count", exp_wb, wb_words);
                if (!hit) begin
                        m_valid[a.idx][way] = 1'b1;
                        m_tag[a.idx][way]   = a.tag;
                        m_dirty[a.idx][way] = 1'b0;
                end
                m_mru[a.idx] = way;
                if (store) begin
                        ref_img[addr]       = wdata;
                        m_dirty[a.idx][way] = 1'b1;
                end
        endtask

        initial begin
                dcache_addr_t a;
                int           cycles;
                int           exp_flush;
                errors    = 0;
                checks    = 0;
                wb_words  = 0;
                aborted   = 1'b0;
                halting   = 1'b0;
                cpu_req   = '0;
                halt      = 1'b0;
                next_wait = 2'd0;
                prev_req  = '0;
                prev_wait = 1'b0;
                void'($urandom(SEED));

                cycles = 0;
                while (nRST !== 1'b1 && cycles < 10) begin
                        next_cycle();
                        #SAMPLE_DLY;
                        cycles++;
                end
                if (nRST !== 1'b1) begin
                        errors++;
                        aborted = 1'b1;
                        $display("Timeout: reset was never released");
                end
                next_cycle();
                #SAMPLE_DLY;
                check_word("dhit", 32'd0, 32'(dhit));
                check_word("mem_req.ren", 32'd0, 32'(mem_req.ren));
                check_word("mem_req.wen", 32'd0, 32'(mem_req.wen));
                check_word("flushed", 32'd0, 32'(flushed));

                for (int n = 0; n < N_OPS && !aborted; n++) begin
                        a.tag    = pool_tag[$urandom_range(0, 3)];
                        a.idx    = pool_idx[$urandom_range(0, 2)];
                        a.blkoff = 1'($urandom_range(0, 1));
                        a.bytoff = 2'b00;
                        next_cycle();
                        if ($urandom_range(0, 3) == 0) begin
                                // idle cycle
                                cpu_req = '0;
                                next_cycle();
                        end
                        do_request(a, $urandom_range(0, 1) == 1, $urandom());
                end

                if (!aborted) begin
                        exp_flush = 0;
                        for (int s = 0; s < SETS; s++) begin
                                for (int w = 0; w < WAYS; w++) begin
                                        if (m_valid[s][w] && m_dirty[s][w]) begin
                                                exp_flush += 2;
                                        end
                                end
                        end
                        next_cycle();
                        cpu_req  = '0;
                        halt     = 1'b1;
                        halting  = 1'b1;
                        wb_words = 0;
                        cycles   = 0;
                        #SAMPLE_DLY;
                        while (flushed !== 1'b1 && cycles < 8 * TIMEOUT) begin
                                next_cycle();
                                #SAMPLE_DLY;
                                cycles++;
                        end
                        if (flushed !== 1'b1) begin
                                errors++;
                                $display("Timeout: flushed did not rise after halt");
                        end else begin
                                check_word("flush write-back word count", exp_flush, wb_words);
                                for (int t = 0; t < 4; t++) begin
                                        for (int i = 0; i < 3; i++) begin
                                                for (int b = 0; b < 2; b++) begin
                                                        a = {pool_tag[t], pool_idx[i], b[0], 2'b00};
                                                        check_word("memory image", expected_word(a),
                                                                   u_mem.read_word(a));
                                                end
                                        end
                                end
                        end
                end

                $display("checks %0d errors %0d", checks, errors);
                if (errors == 0) begin
                        $display("sim passed");
                end else begin
                        $display("sim failed");
                end
                $finish;
        end

endmodule

//--- dcache_tb_clk.sv
module dcache_tb_clk (
        output logic CLK,
        output logic nRST
);

        localparam int HALF = 4;

        initial begin
                CLK  = 1'b0;
                nRST = 1'b0;
                forever #HALF CLK = ~CLK;
        end

        // release away from the rising edge
        initial begin
                repeat (2) @(posedge CLK);
                @(negedge CLK);
                nRST = 1'b1;
        end

endmodule

//--- dcache_tb_mem.sv
module dcache_tb_mem
        import dcache_pkg::*;
(
        input  logic       CLK,
        input  logic       nRST,
        input  mem_req_t   mem_req,
        input  logic [1:0] next_wait,
        output logic       dwait,
        output word_t      dload
);

        // sparse image, keyed by word-aligned byte address
        word_t       img [word_t];
        logic [1:0]  wait_cnt;
        int unsigned wr_count;

        function automatic word_t read_word(input word_t a);
                word_t wa;
                wa = {a[WORD_W-1:2], 2'b00};
                if (img.exists(wa)) begin
                        return img[wa];
                end
                // never written
                return wa ^ 32'h5a5a_0000;
        endfunction

        assign dwait = (mem_req.ren || mem_req.wen) && (wait_cnt != 2'd0);

        always @(mem_req or wr_count) begin
                dload = read_word(mem_req.addr);
        end

        always @(posedge CLK or negedge nRST) begin
                if (!nRST) begin
                        wait_cnt <= 2'd0;
                        wr_count <= 0;
                end else if (mem_req.ren || mem_req.wen) begin
                        if (wait_cnt != 2'd0) begin
                                wait_cnt <= wait_cnt - 2'd1;
                        end else begin
                                // transfer done, next one gets a fresh wait
                                wait_cnt <= next_wait;
                                if (mem_req.wen) begin
                                        img[{mem_req.addr[WORD_W-1:2], 2'b00}] = mem_req.wdata;
                                        wr_count <= wr_count + 1;
                                end
                        end
                end
        end

endmodule
